/* Bender.yml */
package:
  name: rv_core

dependencies: {}

sources:
  - design/rv_pkg.sv
  - design/rv_decode_if.sv
  - design/rv_alu.sv
  - design/rv_regfile.sv
  - design/rv_decode.sv
  - design/rv_control.sv
  - design/rv_core.sv
  - target: simulation
    files:
      - tb/tb_rv_core.sv

/* design/rv_alu.sv */
`timescale 1ns/100ps

module rv_alu (
    input  logic [rv_pkg::alu_op_w-1:0] op,
    input  logic [rv_pkg::xlen-1:0] lhs,
    input  logic [rv_pkg::xlen-1:0] rhs,
    output logic [rv_pkg::xlen-1:0] res
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = rhs[4:0];

    always_comb begin
        res = '0;
        case (op)
            alu_add: res = lhs + rhs;
            alu_sub: res = lhs - rhs;
            alu_sll: res = lhs << shamt;
            alu_srl: res = lhs >> shamt;
            alu_sra: res = $signed(lhs) >>> shamt;
            alu_xor: res = lhs ^ rhs;
            alu_or: res = lhs | rhs;
            alu_and: res = lhs & rhs;
            // compares land in bit 0
            alu_lt: res[0] = $signed(lhs) < $signed(rhs);
            alu_ltu: res[0] = lhs < rhs;
            alu_ge: res[0] = $signed(lhs) >= $signed(rhs);
            alu_geu: res[0] = lhs >= rhs;
            alu_eq: res[0] = lhs == rhs;
            alu_ne: res[0] = lhs != rhs;
            default: res = '0;
        endcase
    end

    // op register holds x until the first execute
    always_comb begin
        assert final ($isunknown(op) || op <= alu_geu);
    end
endmodule

/* design/rv_control.sv */
`timescale 1ns/100ps

module rv_control #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = 32'h1000_0000
) (
    input  logic clk,
    input  logic reset_n,
    input  logic mem_ready,
    input  logic mem_read_data_valid,
    input  logic [rv_pkg::xlen-1:0] mem_read_data,
    output logic mem_read_req,
    output logic [rv_pkg::xlen-1:0] mem_addr,
    output logic [3:0] mem_byte_enable,
    input  logic store_write_ready,
    output logic store_write_req,
    output logic [rv_pkg::xlen-1:0] store_write_addr,
    output logic [rv_pkg::xlen-1:0] store_write_data,
    output logic [3:0] store_write_byte_enable,
    rv_decode_if.control dec,
    output rv_pkg::instr_t instr,
    input  logic [rv_pkg::xlen-1:0] rs1_value,
    input  logic [rv_pkg::xlen-1:0] rs2_value,
    output logic rd_write_enable,
    output logic [rv_pkg::xlen-1:0] rd_write_value,
    output logic [rv_pkg::alu_op_w-1:0] alu_op,
    output logic [rv_pkg::xlen-1:0] alu_lhs,
    output logic [rv_pkg::xlen-1:0] alu_rhs,
    input  logic [rv_pkg::xlen-1:0] alu_res,
    output logic core_error
);
    import rv_pkg::*;

    localparam logic [2:0] st_setup = 3'd0;
    localparam logic [2:0] st_fetch = 3'd1;
    localparam logic [2:0] st_execute = 3'd2;
    localparam logic [2:0] st_store = 3'd3;
    localparam logic [2:0] st_writeback = 3'd4;
    localparam logic [2:0] st_error = 3'd5;

    logic [2:0] state;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_link;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] lhs_value;
    logic [xlen-1:0] rhs_value;

    assign mem_byte_enable = 4'hf;
    assign pc_link = pc + 32'd4;

    always_comb begin
        case (dec.lhs_sel)
            sel_imm: lhs_value = dec.imm;
            sel_pc: lhs_value = pc;
            default: lhs_value = rs1_value;
        endcase
        case (dec.rhs_sel)
            sel_imm: rhs_value = dec.imm;
            sel_pc: rhs_value = pc;
            default: rhs_value = rs2_value;
        endcase
    end

    always_comb begin
        next_pc = pc_link;
        case (dec.instr_class)
            cls_jal: next_pc = alu_res;
            cls_jalr: next_pc = {alu_res[xlen-1:1], 1'b0};
            cls_branch: next_pc = alu_res[0] ? pc + dec.imm : pc_link;
            default: next_pc = pc_link;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= st_setup;
            pc <= reset_pc;
            mem_read_req <= 1'b0;
            store_write_req <= 1'b0;
            rd_write_enable <= 1'b0;
            core_error <= 1'b0;
        end else begin
            rd_write_enable <= 1'b0;
            case (state)
                st_setup: begin
                    mem_addr <= pc;
                    mem_read_req <= 1'b1;
                    state <= st_fetch;
                end
                st_fetch: begin
                    if (mem_ready) begin
                        mem_read_req <= 1'b0;
                    end
                    // data only counts once the request is gone
                    if (!mem_read_req && mem_read_data_valid) begin
                        instr <= mem_read_data;
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    alu_op <= dec.alu_op;
                    alu_lhs <= lhs_value;
                    alu_rhs <= rhs_value;
                    if (dec.illegal) begin
                        state <= st_error;
                        core_error <= 1'b1;
                    end else begin
                        state <= (dec.instr_class == cls_store) ? st_store : st_writeback;
                    end
                end
                st_store: begin
                    store_write_req <= 1'b1;
                    store_write_addr <= alu_res;
                    store_write_data <= rs2_value;
                    case (instr.s_fmt.funct3)
                        f3_sb: store_write_byte_enable <= 4'b0001;
                        f3_sh: store_write_byte_enable <= 4'b0011;
                        default: store_write_byte_enable <= 4'b1111;
                    endcase
                    state <= st_writeback;
                end
                st_writeback: begin
                    if (store_write_ready) begin
                        store_write_req <= 1'b0;
                    end
                    if (!store_write_req || store_write_ready) begin
                        rd_write_enable <= dec.instr_class inside {cls_alu, cls_jal, cls_jalr};
                        rd_write_value <= (dec.instr_class == cls_alu) ? alu_res : pc_link;
                        pc <= next_pc;
                        if (next_pc[1:0] != 2'b00) begin
                            state <= st_error;
                            core_error <= 1'b1;
                        end else begin
                            mem_addr <= next_pc;
                            mem_read_req <= 1'b1;
                            state <= st_fetch;
                        end
                    end
                end
                default: state <= st_error;
            endcase
        end
    end

    a_one_port: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_read_req && store_write_req));

    a_quiet_after_error: assert property (@(posedge clk) disable iff (!reset_n)
        core_error |=> !$rose(mem_read_req) && !$rose(store_write_req));
endmodule

/* design/rv_core.sv */
`timescale 1ns/100ps

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = 32'h1000_0000
) (
    input  logic clk,
    input  logic reset_n,
    input  logic mem_ready,
    input  logic mem_read_data_valid,
    input  logic [rv_pkg::xlen-1:0] mem_read_data,
    output logic mem_read_req,
    output logic [rv_pkg::xlen-1:0] mem_addr,
    output logic [3:0] mem_byte_enable,
    input  logic store_write_ready,
    output logic store_write_req,
    output logic [rv_pkg::xlen-1:0] store_write_addr,
    output logic [rv_pkg::xlen-1:0] store_write_data,
    output logic [3:0] store_write_byte_enable,
    output logic core_error
);
    import rv_pkg::*;

    instr_t instr;
    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
    logic rd_write_enable;
    logic [xlen-1:0] rd_write_value;
    logic [alu_op_w-1:0] alu_op;
    logic [xlen-1:0] alu_lhs;
    logic [xlen-1:0] alu_rhs;
    logic [xlen-1:0] alu_res;

    rv_decode_if dec_if ();

    rv_decode i_decode (
        .instr(instr),
        .dec(dec_if.decoder)
    );

    rv_alu i_alu (
        .op(alu_op),
        .lhs(alu_lhs),
        .rhs(alu_rhs),
        .res(alu_res)
    );

    // register indices come straight from the latched word
    rv_regfile i_regfile (
        .clk(clk),
        .reset_n(reset_n),
        .read_addr1(instr.r_fmt.rs1),
        .read_addr2(instr.r_fmt.rs2),
        .write_addr(instr.r_fmt.rd),
        .read_data1(rs1_value),
        .read_data2(rs2_value),
        .write_enable(rd_write_enable),
        .write_data(rd_write_value)
    );

    rv_control #(
        .reset_pc(reset_pc)
    ) i_control (
        .clk(clk),
        .reset_n(reset_n),
        .mem_ready(mem_ready),
        .mem_read_data_valid(mem_read_data_valid),
        .mem_read_data(mem_read_data),
        .mem_read_req(mem_read_req),
        .mem_addr(mem_addr),
        .mem_byte_enable(mem_byte_enable),
        .store_write_ready(store_write_ready),
        .store_write_req(store_write_req),
        .store_write_addr(store_write_addr),
        .store_write_data(store_write_data),
        .store_write_byte_enable(store_write_byte_enable),
        .dec(dec_if.control),
        .instr(instr),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .rd_write_enable(rd_write_enable),
        .rd_write_value(rd_write_value),
        .alu_op(alu_op),
        .alu_lhs(alu_lhs),
        .alu_rhs(alu_rhs),
        .alu_res(alu_res),
        .core_error(core_error)
    );
endmodule

/* design/rv_decode.sv */
`timescale 1ns/100ps

module rv_decode (
    input rv_pkg::instr_t instr,
    rv_decode_if.decoder dec
);
    import rv_pkg::*;

    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] j_imm;
    logic [xlen-1:0] shamt_imm;
    logic is_shift;
    logic alt;

    assign i_imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign s_imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign b_imm = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                    instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
    assign u_imm = {instr.u_fmt.imm, 12'h0};
    assign j_imm = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                    instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};
    assign shamt_imm = {{(xlen-reg_addr_w){1'b0}}, instr.r_fmt.rs2};
    assign is_shift = instr.i_fmt.funct3 == f3_sll || instr.i_fmt.funct3 == f3_srl;
    // instruction bit 30
    assign alt = instr.r_fmt.funct7[5];

    always_comb begin
        dec.lhs_sel = sel_rs;
        dec.rhs_sel = sel_rs;
        dec.imm = i_imm;
        dec.instr_class = cls_alu;
        dec.illegal = 1'b0;

        case (instr.r_fmt.funct3)
            3'b000: dec.alu_op = (instr.r_fmt.opcode == op_reg && alt) ? alu_sub : alu_add;
            3'b001: dec.alu_op = alu_sll;
            3'b010: dec.alu_op = alu_lt;
            3'b011: dec.alu_op = alu_ltu;
            3'b100: dec.alu_op = alu_xor;
            3'b101: dec.alu_op = alt ? alu_sra : alu_srl;
            3'b110: dec.alu_op = alu_or;
            default: dec.alu_op = alu_and;
        endcase

        case (instr.r_fmt.opcode)
            op_lui: begin
                // imm | imm passes the upper immediate through
                dec.alu_op = alu_or;
                dec.lhs_sel = sel_imm;
                dec.rhs_sel = sel_imm;
                dec.imm = u_imm;
            end
            op_auipc: begin
                dec.alu_op = alu_add;
                dec.lhs_sel = sel_pc;
                dec.rhs_sel = sel_imm;
                dec.imm = u_imm;
            end
            op_jal: begin
                dec.alu_op = alu_add;
                dec.lhs_sel = sel_pc;
                dec.rhs_sel = sel_imm;
                dec.imm = j_imm;
                dec.instr_class = cls_jal;
            end
            op_jalr: begin
                dec.alu_op = alu_add;
                dec.rhs_sel = sel_imm;
                dec.instr_class = cls_jalr;
            end
            op_branch: begin
                dec.imm = b_imm;
                dec.instr_class = cls_branch;
                case (instr.b_fmt.funct3)
                    3'b000: dec.alu_op = alu_eq;
                    3'b001: dec.alu_op = alu_ne;
                    3'b100: dec.alu_op = alu_lt;
                    3'b101: dec.alu_op = alu_ge;
                    3'b110: dec.alu_op = alu_ltu;
                    3'b111: dec.alu_op = alu_geu;
                    default: dec.illegal = 1'b1;
                endcase
            end
            op_store: begin
                dec.alu_op = alu_add;
                dec.rhs_sel = sel_imm;
                dec.imm = s_imm;
                dec.instr_class = cls_store;
                dec.illegal = instr.s_fmt.funct3 > f3_sw;
            end
            op_imm: begin
                dec.rhs_sel = sel_imm;
                dec.imm = is_shift ? shamt_imm : i_imm;
            end
            op_reg: dec.rhs_sel = sel_rs;
            default: dec.illegal = 1'b1;
        endcase
    end
endmodule

/* design/rv_decode_if.sv */
`timescale 1ns/100ps

interface rv_decode_if;
    import rv_pkg::*;

    logic [alu_op_w-1:0] alu_op;
    logic [sel_w-1:0] lhs_sel;
    logic [sel_w-1:0] rhs_sel;
    logic [xlen-1:0] imm;
    logic [class_w-1:0] instr_class;
    logic illegal;

    modport decoder (
        output alu_op, lhs_sel, rhs_sel, imm, instr_class, illegal
    );

    modport control (
        input alu_op, lhs_sel, rhs_sel, imm, instr_class, illegal
    );
endinterface

/* design/rv_pkg.sv */
package rv_pkg;
    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w = 4;
    localparam int class_w = 3;
    localparam int sel_w = 2;

    // alu operation codes, contiguous up to alu_geu
    localparam logic [alu_op_w-1:0] alu_add = 4'd0;
    localparam logic [alu_op_w-1:0] alu_sub = 4'd1;
    localparam logic [alu_op_w-1:0] alu_sll = 4'd2;
    localparam logic [alu_op_w-1:0] alu_lt = 4'd3;
    localparam logic [alu_op_w-1:0] alu_ltu = 4'd4;
    localparam logic [alu_op_w-1:0] alu_xor = 4'd5;
    localparam logic [alu_op_w-1:0] alu_srl = 4'd6;
    localparam logic [alu_op_w-1:0] alu_sra = 4'd7;
    localparam logic [alu_op_w-1:0] alu_or = 4'd8;
    localparam logic [alu_op_w-1:0] alu_and = 4'd9;
    localparam logic [alu_op_w-1:0] alu_eq = 4'd10;
    localparam logic [alu_op_w-1:0] alu_ne = 4'd11;
    localparam logic [alu_op_w-1:0] alu_ge = 4'd12;
    localparam logic [alu_op_w-1:0] alu_geu = 4'd13;

    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_jalr = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_reg = 7'b0110011;

    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    // how the control unit finishes an instruction
    localparam logic [class_w-1:0] cls_alu = 3'd0;
    localparam logic [class_w-1:0] cls_jal = 3'd1;
    localparam logic [class_w-1:0] cls_jalr = 3'd2;
    localparam logic [class_w-1:0] cls_branch = 3'd3;
    localparam logic [class_w-1:0] cls_store = 3'd4;

    localparam logic [sel_w-1:0] sel_rs = 2'd0;
    localparam logic [sel_w-1:0] sel_imm = 2'd1;
    localparam logic [sel_w-1:0] sel_pc = 2'd2;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm;
            logic [4:0] rd;
            logic [6:0] opcode;
        } u_fmt;
        struct packed {
            logic imm20;
            logic [9:0] imm10_1;
            logic imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_t;
endpackage

/* design/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
    input  logic clk,
    input  logic reset_n,
    input  logic [rv_pkg::reg_addr_w-1:0] read_addr1,
    input  logic [rv_pkg::reg_addr_w-1:0] read_addr2,
    input  logic [rv_pkg::reg_addr_w-1:0] write_addr,
    output logic [rv_pkg::xlen-1:0] read_data1,
    output logic [rv_pkg::xlen-1:0] read_data2,
    input  logic write_enable,
    input  logic [rv_pkg::xlen-1:0] write_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    assign read_data1 = regs[read_addr1];
    assign read_data2 = regs[read_addr2];

    // x0 is cleared at reset and never written
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            regs <= '{default: '0};
        end else if (write_enable && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    a_x0_zero: assert property (@(posedge clk) disable iff (!reset_n)
        read_addr1 == '0 |-> read_data1 == '0);
endmodule

/* tb/rv_core_trace.txt */
# p <address> <instruction> | s <behavior> <address> <data> <byte enable>
# x <address of the illegal word where the core must stop>
# arithmetic, x31 holds the store base
p 10000000 20000fb7
p 10000004 ffb00093
p 10000008 00300113
p 1000000c 402081b3
p 10000010 003fa023
p 10000014 4021d213
p 10000018 002112b3
p 1000001c 00524333
p 10000020 006fa223
p 10000024 0020a3b3
p 10000028 0020b433
p 1000002c 00439493
p 10000030 01c0d513
p 10000034 00a485b3
p 10000038 408585b3
p 1000003c 03c5f593
p 10000040 00bfa423
# lui and auipc
p 10000044 abcde637
p 10000048 00001697
p 1000004c 00cfa623
p 10000050 00dfa823
# per kind: not taken, taken, then a store that must be skipped
p 10000054 00208463
p 10000058 00210463
p 1000005c 042fa023
p 10000060 00211463
p 10000064 00209463
p 10000068 042fa023
p 1000006c 00114463
p 10000070 0020c463
p 10000074 042fa023
p 10000078 0020d463
p 1000007c 00115463
p 10000080 042fa023
p 10000084 0020e463
p 10000088 00116463
p 1000008c 042fa023
p 10000090 00117463
p 10000094 0020f463
p 10000098 042fa023
p 1000009c 001faa23
# jal and jalr, jalr target has bit 0 set
p 100000a0 0080076f
p 100000a4 042fa023
p 100000a8 00efac23
p 100000ac 011707e7
p 100000b0 042fa023
p 100000b4 00ffae23
# sb, sh, sw of the same word, then ecall
p 100000b8 76560813
p 100000bc 030f8023
p 100000c0 030f9223
p 100000c4 030fa423
p 100000c8 00000073
s 1 20000000 fffffff8 f
s 1 20000004 ffffffe6 f
s 1 20000008 0000001c f
s 2 2000000c abcde000 f
s 2 20000010 10001048 f
s 3 20000014 fffffffb f
s 4 20000018 100000a4 f
s 4 2000001c 100000b0 f
s 5 20000020 abcde765 1
s 5 20000024 abcde765 3
s 5 20000028 abcde765 f
x 100000c8

/* tb/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core;
    logic clk;
    logic reset_n;
    logic mem_ready;
    logic mem_read_data_valid;
    logic [31:0] mem_read_data;
    logic mem_read_req;
    logic [31:0] mem_addr;
    logic [3:0] mem_byte_enable;
    logic store_write_ready;
    logic store_write_req;
    logic [31:0] store_write_addr;
    logic [31:0] store_write_data;
    logic [3:0] store_write_byte_enable;
    logic core_error;

    logic [31:0] program_mem [logic [31:0]];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0] exp_be [$];
    int exp_group [$];
    logic [31:0] stop_addr;
    logic [31:0] last_fetch_addr;
    int store_index;
    int fetch_phase;
    int fetch_delay;
    int store_phase;
    int store_delay;
    int cycle_count;
    int max_cycles;
    int group_errors [1:6];
    bit group_done [1:6];
    int pass_count;
    int fail_count;

    rv_core i_dut (
        .clk(clk),
        .reset_n(reset_n),
        .mem_ready(mem_ready),
        .mem_read_data_valid(mem_read_data_valid),
        .mem_read_data(mem_read_data),
        .mem_read_req(mem_read_req),
        .mem_addr(mem_addr),
        .mem_byte_enable(mem_byte_enable),
        .store_write_ready(store_write_ready),
        .store_write_req(store_write_req),
        .store_write_addr(store_write_addr),
        .store_write_data(store_write_data),
        .store_write_byte_enable(store_write_byte_enable),
        .core_error(core_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic string group_name(int grp);
        case (grp)
            1: return "arithmetic";
            2: return "upper immediates";
            3: return "branches";
            4: return "jumps";
            5: return "store encoding";
            default: return "error stop";
        endcase
    endfunction

    // stores not yet seen decide which behavior a stray error belongs to
    function automatic int current_group();
        return (store_index < exp_addr.size()) ? exp_group[store_index] : 6;
    endfunction

    task automatic report_group(int grp);
        group_done[grp] = 1'b1;
        if (group_errors[grp] == 0) begin
            pass_count++;
            $display("behavior %0d, %s: pass", grp, group_name(grp));
        end else begin
            fail_count++;
            $display("behavior %0d, %s: fail with %0d errors", grp, group_name(grp),
                     group_errors[grp]);
        end
    endtask

    task automatic value_error(int grp, string name, logic [31:0] expected,
                               logic [31:0] actual);
        group_errors[grp]++;
        $display("error: %s expected %h, got %h at %0t", name, expected, actual, $time);
    endtask

    task automatic load_trace();
        int fd;
        logic [7:0] tag;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] g;
        logic [31:0] be;
        logic [8*128-1:0] line;
        fd = $fopen("tb/rv_core_trace.txt", "r");
        if (fd == 0) begin
            group_errors[6]++;
            $display("could not open the trace file tb/rv_core_trace.txt");
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                case (tag)
                    "#": void'($fgets(line, fd));
                    "p": begin
                        void'($fscanf(fd, "%h %h", a, w));
                        program_mem[a] = w;
                    end
                    "s": begin
                        void'($fscanf(fd, "%h %h %h %h", g, a, w, be));
                        exp_group.push_back(g);
                        exp_addr.push_back(a);
                        exp_data.push_back(w);
                        exp_be.push_back(be[3:0]);
                    end
                    "x": void'($fscanf(fd, "%h", stop_addr));
                    default: begin
                        group_errors[6]++;
                        $display("the trace holds a line of unknown type");
                    end
                endcase
            end
            $fclose(fd);
        end
    endtask

    // instruction memory with random ready and data-valid delays
    task automatic answer_fetch();
        if (fetch_phase == 0 && mem_read_req) begin
            last_fetch_addr = mem_addr;
            fetch_delay = $urandom % 4;
            fetch_phase = 1;
            if (mem_byte_enable !== 4'hf) begin
                value_error(current_group(), "mem_byte_enable", 32'hf, {28'h0, mem_byte_enable});
            end
        end
        if (fetch_phase == 1) begin
            if (mem_read_req !== 1'b1) begin
                group_errors[current_group()]++;
                $display("fetch request dropped before mem_ready at %0t", $time);
            end
            if (fetch_delay == 0) begin
                mem_ready = 1'b1;
                fetch_delay = $urandom % 2;
                fetch_phase = 2;
            end else begin
                fetch_delay--;
            end
        end else if (fetch_phase == 2) begin
            if (mem_read_req !== 1'b0) begin
                group_errors[current_group()]++;
                $display("fetch request still high after mem_ready at %0t", $time);
            end
            if (fetch_delay == 0) begin
                if (program_mem.exists(last_fetch_addr)) begin
                    mem_read_data = program_mem[last_fetch_addr];
                end else begin
                    mem_read_data = 32'h0;
                    group_errors[current_group()]++;
                    $display("fetch from %h, where the trace holds no program word",
                             last_fetch_addr);
                end
                mem_read_data_valid = 1'b1;
                fetch_phase = 0;
            end else begin
                fetch_delay--;
            end
        end
    endtask

    task automatic check_store();
        int grp;
        if (store_index >= exp_addr.size()) begin
            group_errors[6]++;
            $display("unexpected store to %h after the last expected store", store_write_addr);
        end else begin
            grp = exp_group[store_index];
            if (store_write_addr !== exp_addr[store_index]) begin
                value_error(grp, "store_write_addr", exp_addr[store_index], store_write_addr);
            end
            if (store_write_data !== exp_data[store_index]) begin
                value_error(grp, "store_write_data", exp_data[store_index], store_write_data);
            end
            if (store_write_byte_enable !== exp_be[store_index]) begin
                value_error(grp, "store_write_byte_enable", {28'h0, exp_be[store_index]},
                            {28'h0, store_write_byte_enable});
            end
            store_index++;
            if (store_index == exp_addr.size() || exp_group[store_index] != grp) begin
                report_group(grp);
            end
        end
    endtask

    // one write counted per ready cycle
    task automatic accept_store();
        if (store_phase == 0 && store_write_req) begin
            store_delay = $urandom % 4;
            store_phase = 1;
        end
        if (store_phase == 1) begin
            if (store_write_req !== 1'b1) begin
                group_errors[current_group()]++;
                $display("store request dropped before store_write_ready at %0t", $time);
            end
            if (store_delay == 0) begin
                store_write_ready = 1'b1;
                store_phase = 0;
                check_store();
            end else begin
                store_delay--;
            end
        end
    endtask

    always @(posedge clk) begin
        #2;
        cycle_count++;
        if (cycle_count > max_cycles) begin
            $display("timeout after %0d cycles without the core stopping", cycle_count);
            $display("TEST FAILED");
            $finish;
        end else begin
            mem_ready = 1'b0;
            mem_read_data_valid = 1'b0;
            store_write_ready = 1'b0;
            answer_fetch();
            accept_store();
        end
    end

    initial begin
        bit quiet;
        reset_n = 1'b0;
        mem_ready = 1'b0;
        mem_read_data_valid = 1'b0;
        mem_read_data = 32'h0;
        store_write_ready = 1'b0;
        store_index = 0;
        fetch_phase = 0;
        store_phase = 0;
        cycle_count = 0;
        pass_count = 0;
        fail_count = 0;
        for (int g = 1; g <= 6; g++) begin
            group_errors[g] = 0;
            group_done[g] = 1'b0;
        end
        void'($urandom(32'h7c36));
        load_trace();
        max_cycles = 80 * program_mem.num() + 100;

        repeat (4) @(posedge clk);
        #2;
        reset_n = 1'b1;

        while (core_error !== 1'b1) @(negedge clk);
        if (last_fetch_addr !== stop_addr) begin
            value_error(6, "mem_addr", stop_addr, last_fetch_addr);
        end
        quiet = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (mem_read_req !== 1'b0 || store_write_req !== 1'b0) begin
                quiet = 1'b0;
            end
        end
        if (!quiet) begin
            group_errors[6]++;
            $display("a request was raised after core_error went high");
        end
        for (int g = 1; g <= 5; g++) begin
            if (!group_done[g]) begin
                group_errors[g]++;
                $display("the core stopped before all stores of behavior %0d were seen", g);
                report_group(g);
            end
        end
        report_group(6);

        $display("behaviors passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end
endmodule

/* verilog.f */
design/rv_pkg.sv
design/rv_decode_if.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_control.sv
design/rv_core.sv
tb/tb_rv_core.sv
